// File: verif/tx_desc_tests.txt
# en dpp pthresh hthresh lwthresh tdt rs_pattern(hex) fetches first_size last_size
# rs_pattern bit i is the RS flag of descriptor i modulo 32
1 0 0 0 4 5 0000001f 1 5 5
1 0 0 0 0 8 00000055 1 8 8
1 0 2 1 6 20 0000a5a5 1 20 20
1 1 0 0 3 5 00000012 5 1 1
1 0 0 10 8 100 f0f0f0f1 2 64 36
1 1 3 0 0 4 00000000 4 1 1
0 0 0 0 4 6 ffffffff 0 0 0
1 0 0 0 2 64 80000001 1 64 64

// File: tx_desc_ctrl.f
hw/tx_desc_pkg.sv
hw/host_ring_tracker.sv
hw/local_desc_queues.sv
hw/idma_scheduler.sv
hw/teng_dispatcher.sv
hw/tx_desc_ctrl.sv
verif/tb_tx_desc_ctrl.sv

// File: Bender.yml
package:
  name: tx_desc_ctrl

sources:
  - hw/tx_desc_pkg.sv
  - hw/host_ring_tracker.sv
  - hw/local_desc_queues.sv
  - hw/idma_scheduler.sv
  - hw/teng_dispatcher.sv
  - hw/tx_desc_ctrl.sv
  - target: simulation
    files:
      - verif/tb_tx_desc_ctrl.sv

// File: verif/tb_tx_desc_ctrl.sv
`timescale 1ns/1ps

module tb_tx_desc_ctrl import tx_desc_pkg::*; ;

	localparam host_addr_t base_addr   = 64'h0000_0012_3400_0000;
	localparam int         max_cycles  = 50000;
	localparam int         idle_cycles = 200;

	logic         aclk;
	logic         aresetn;
	tx_cfg_t      cfg;
	desc_idx_t    tdh;
	logic         tdh_set;
	desc_idx_t    tdh_fb;
	desc_idx_t    tdt;
	logic         tdt_set;
	logic         txdw;
	logic         txqe;
	logic         txd_low;
	stream_beat_t idma_cmd;
	logic         idma_cmd_valid;
	logic         idma_cmd_ready;
	stream_beat_t idma_rsp;
	logic         idma_rsp_valid;
	logic         idma_rsp_ready;
	stream_beat_t teng_cmd;
	logic         teng_cmd_valid;
	logic         teng_cmd_ready;
	stream_beat_t teng_rsp;
	logic         teng_rsp_valid;
	logic         teng_rsp_ready;

	logic [31:0] rng;

	tx_desc_ctrl #(
		.max_burst (64)
	) i_dut (
		.aclk           (aclk),
		.aresetn        (aresetn),
		.cfg            (cfg),
		.tdh            (tdh),
		.tdh_set        (tdh_set),
		.tdh_fb         (tdh_fb),
		.tdt            (tdt),
		.tdt_set        (tdt_set),
		.txdw           (txdw),
		.txqe           (txqe),
		.txd_low        (txd_low),
		.idma_cmd       (idma_cmd),
		.idma_cmd_valid (idma_cmd_valid),
		.idma_cmd_ready (idma_cmd_ready),
		.idma_rsp       (idma_rsp),
		.idma_rsp_valid (idma_rsp_valid),
		.idma_rsp_ready (idma_rsp_ready),
		.teng_cmd       (teng_cmd),
		.teng_cmd_valid (teng_cmd_valid),
		.teng_cmd_ready (teng_cmd_ready),
		.teng_rsp       (teng_rsp),
		.teng_rsp_valid (teng_rsp_valid),
		.teng_rsp_ready (teng_rsp_ready)
	);

	initial begin
		aclk = 1'b0;
		forever begin
			#2 aclk = ~aclk;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Back-pressure of zero to three cycles
	task automatic draw_delay(output int d);
		rng = xorshift32(rng);
		d = int'(rng[1:0]);
	endtask

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Checks failed");
			$fatal(1);
		end
	endtask

	task automatic apply_reset();
		aresetn = 1'b0;
		repeat (10) @(negedge aclk);
		aresetn = 1'b1;
		@(negedge aclk);
		check(idma_cmd_valid, 0, "idma_cmd_valid after reset");
		check(idma_rsp_ready, 0, "idma_rsp_ready after reset");
		check(teng_cmd_valid, 0, "teng_cmd_valid after reset");
		check(teng_rsp_ready, 0, "teng_rsp_ready after reset");
		check({txdw, txqe, txd_low}, 0, "interrupts after reset");
		check(tdh_fb, 0, "tdh_fb after reset");
	endtask

	task automatic run_test(input logic en, input logic dpp, input int pth, input int hth,
		input int lwth, input int n, input logic [31:0] rs, input int nfetch,
		input int first_size, input int last_size);
		int         cyc;
		int         beat;
		int         cmd_delay;
		int         rsp_delay;
		int         eng_delay;
		int         eng_rsp_delay;
		bit         rsp_owed;
		bit         rsp_fire;
		bit         eng_owed;
		bit         eng_fire;
		bit         eng_rs;
		bit         finished;
		bit         qe_seen;
		int         fetches;
		int         curr_exp;
		int         sent;
		int         wb_ptr;
		int         wb_cmds;
		int         txdw_cnt;
		int         exp_rs;
		int         d;
		int         size;
		int         prev_head;
		int         low_wait;
		int         pend;
		host_addr_t exp_addr;
		dma_word_t  word;

		cfg          = '0;
		cfg.en       = en;
		cfg.base     = base_addr;
		cfg.len      = 13'd32;
		cfg.dpp      = dpp;
		cfg.pthresh  = thresh_t'(pth);
		cfg.hthresh  = thresh_t'(hth);
		cfg.lwthresh = thresh_t'(lwth);
		apply_reset();
		tdt     = desc_idx_t'(n);
		tdt_set = 1'b1;
		@(negedge aclk);
		tdt_set = 1'b0;

		beat          = 0;
		cmd_delay     = 0;
		eng_delay     = 0;
		rsp_owed      = 0;
		rsp_fire      = 0;
		eng_owed      = 0;
		eng_fire      = 0;
		eng_rs        = 0;
		fetches       = 0;
		curr_exp      = 0;
		sent          = 0;
		wb_ptr        = 0;
		wb_cmds       = 0;
		txdw_cnt      = 0;
		qe_seen       = 0;
		finished      = 0;
		cyc           = 0;
		exp_rs        = 0;
		rsp_delay     = 0;
		eng_rsp_delay = 0;
		prev_head     = 0;
		low_wait      = 0;
		pend          = 0;
		exp_addr      = '0;
		for (int i = 0; i < n; i++) begin
			exp_rs += rs[i % 32];
		end

		while (!finished) begin
			cyc++;
			if (cyc > max_cycles) begin
				$display("Timeout: descriptors were not all written back in time");
				$display("Checks failed");
				$fatal(1);
			end
			if (!en) begin
				check({idma_cmd_valid, teng_cmd_valid}, 0, "command while disabled");
			end

			// One DMA command beat accepted per ready pulse
			if (idma_cmd_ready) begin
				idma_cmd_ready = 1'b0;
				draw_delay(cmd_delay);
			end else if (idma_cmd_valid) begin
				if (cmd_delay > 0) begin
					cmd_delay--;
				end else begin
					word = idma_cmd.data;
					case (beat)
						0: begin
							if (word[31]) begin
								d = wb_ptr;
								while (d < n && !rs[d % 32]) begin
									d++;
								end
								check(d < n, 1, "write-back without an RS descriptor");
								wb_ptr   = d + 1;
								wb_cmds++;
								exp_addr = base_addr + host_addr_t'(d * 16 + 12);
								check(word, {1'b1, 3'b000, 12'd1, 16'((d % 256) * 16 + 12)},
									"write-back command word");
							end else begin
								check(fetches < nfetch, 1, "fetch beyond expected count");
								size     = (fetches == nfetch - 1) ? last_size : first_size;
								exp_addr = base_addr + host_addr_t'(curr_exp * 16);
								check(word, {1'b0, 3'b000, 12'(size * 16),
									16'((curr_exp % 256) * 16)}, "fetch command word");
								curr_exp += size;
								fetches++;
							end
							check(idma_cmd.last, 0, "last on command beat 0");
						end
						1: begin
							check(word, exp_addr[31:0], "host address low");
							check(idma_cmd.last, 0, "last on command beat 1");
						end
						default: begin
							check(word, exp_addr[63:32], "host address high");
							check(idma_cmd.last, 1, "last on command beat 2");
							rsp_owed = 1;
							draw_delay(rsp_delay);
						end
					endcase
					beat = (beat + 1) % 3;
					idma_cmd_ready = 1'b1;
				end
			end

			// DMA response
			if (rsp_fire) begin
				idma_rsp_valid = 1'b0;
				rsp_fire       = 0;
			end else begin
				if (rsp_owed) begin
					if (rsp_delay > 0) begin
						rsp_delay--;
					end else begin
						idma_rsp.data  = '0;
						idma_rsp.last  = 1'b1;
						idma_rsp_valid = 1'b1;
						rsp_owed       = 0;
					end
				end
				if (idma_rsp_valid && idma_rsp_ready) begin
					rsp_fire = 1;
				end
			end

			// Transmit engine command
			if (teng_cmd_ready) begin
				teng_cmd_ready = 1'b0;
				eng_owed       = 1;
				draw_delay(eng_delay);
				draw_delay(eng_rsp_delay);
			end else if (teng_cmd_valid) begin
				if (eng_delay > 0) begin
					eng_delay--;
				end else begin
					check(sent < curr_exp, 1, "engine command for an unfetched slot");
					check(teng_cmd.data, {16'h0000, 16'((sent % 256) * 16)}, "engine slot address");
					check(teng_cmd.last, 1, "engine command last");
					eng_rs = rs[sent % 32];
					sent++;
					teng_cmd_ready = 1'b1;
				end
			end

			// Transmit engine completion with the RS flag in bit 16
			if (eng_fire) begin
				teng_rsp_valid = 1'b0;
				eng_fire       = 0;
			end else begin
				if (eng_owed) begin
					if (eng_rsp_delay > 0) begin
						eng_rsp_delay--;
					end else begin
						teng_rsp.data  = {15'd0, eng_rs, 16'h0000};
						teng_rsp.last  = 1'b1;
						teng_rsp_valid = 1'b1;
						eng_owed       = 0;
					end
				end
				if (teng_rsp_valid && teng_rsp_ready) begin
					eng_fire = 1;
				end
			end

			if (txdw) begin
				check(txdw_cnt < wb_cmds, 1, "txdw without a write-back command");
				txdw_cnt++;
			end
			// Host head moves one descriptor per dequeue
			if (int'(tdh_fb) != prev_head) begin
				check(tdh_fb, prev_head + 1, "tdh_fb step");
				prev_head++;
				if (n - prev_head < lwth) begin
					low_wait = 1;
				end
			end
			if (txd_low) begin
				pend = n - int'(tdh_fb);
				check(pend < lwth, 1, "txd_low with pending at or above lwthresh");
				low_wait = 0;
			end else if (low_wait > 0) begin
				low_wait++;
				check(low_wait <= 8, 1, "txd_low after pending fell below lwthresh");
			end
			if (txqe) begin
				qe_seen = 1;
				check(tdh_fb, n, "tdh_fb when queue empty");
				check(txd_low, lwth != 0, "txd_low with the queue empty");
			end
			finished = en ? (qe_seen && tdh_fb == desc_idx_t'(n)) : (cyc >= idle_cycles);
			@(negedge aclk);
		end

		check(fetches, en ? nfetch : 0, "number of fetches");
		check(sent, en ? n : 0, "number of engine commands");
		check(wb_cmds, en ? exp_rs : 0, "number of write-back commands");
		check(txdw_cnt, en ? exp_rs : 0, "number of txdw pulses");
	endtask

	initial begin
		int          fd;
		int          ntests;
		string       line;
		int          en;
		int          dpp;
		int          pth;
		int          hth;
		int          lwth;
		int          n;
		logic [31:0] rs;
		int          nfetch;
		int          first_size;
		int          last_size;

		rng            = 32'h9626_dd93;
		aresetn        = 1'b0;
		cfg            = '0;
		tdh            = '0;
		tdh_set        = 1'b0;
		tdt            = '0;
		tdt_set        = 1'b0;
		idma_cmd_ready = 1'b0;
		idma_rsp       = '0;
		idma_rsp_valid = 1'b0;
		teng_cmd_ready = 1'b0;
		teng_rsp       = '0;
		teng_rsp_valid = 1'b0;
		ntests         = 0;

		fd = $fopen("verif/tx_desc_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open the test vector file");
			$display("Checks failed");
			$fatal(1);
		end
		while ($fgets(line, fd)) begin
			if (line.len() > 0 && line[0] != "#") begin
				if ($sscanf(line, "%d %d %d %d %d %d %h %d %d %d", en, dpp, pth, hth, lwth,
					n, rs, nfetch, first_size, last_size) == 10) begin
					run_test(en[0], dpp[0], pth, hth, lwth, n, rs, nfetch, first_size,
						last_size);
					ntests++;
				end
			end
		end
		$fclose(fd);
		if (ntests == 0) begin
			$display("No tests were found in the test vector file");
			$display("Checks failed");
			$fatal(1);
		end else begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule

// File: hw/tx_desc_ctrl.sv
`timescale 1ns/1ps

module tx_desc_ctrl import tx_desc_pkg::*; #(
	parameter int unsigned max_burst = 64
) (
	input  logic         aclk,
	input  logic         aresetn,
	input  tx_cfg_t      cfg,
	input  desc_idx_t    tdh,
	input  logic         tdh_set,
	output desc_idx_t    tdh_fb,
	input  desc_idx_t    tdt,
	input  logic         tdt_set,
	output logic         txdw,
	output logic         txqe,
	output logic         txd_low,
	// DMA engine
	output stream_beat_t idma_cmd,
	output logic         idma_cmd_valid,
	input  logic         idma_cmd_ready,
	input  stream_beat_t idma_rsp,
	input  logic         idma_rsp_valid,
	output logic         idma_rsp_ready,
	// Transmit engine
	output stream_beat_t teng_cmd,
	output logic         teng_cmd_valid,
	input  logic         teng_cmd_ready,
	input  stream_beat_t teng_rsp,
	input  logic         teng_rsp_valid,
	output logic         teng_rsp_ready
);

	logic       wb_done;
	logic       fetch_done;
	slot_cnt_t  fetch_num;
	desc_idx_t  host_fresh;
	host_addr_t wb_addr;
	host_addr_t rd_addr;
	slot_idx_t  in_head;
	slot_idx_t  in_tail;
	slot_idx_t  out_head;
	slot_cnt_t  in_num;
	slot_cnt_t  out_num;
	slot_cnt_t  local_pending;
	slot_cnt_t  local_available;
	logic       rs_flag;
	logic       in_dequeue;
	logic       teng_done;
	logic       teng_rs;

	host_ring_tracker i_host_ring_tracker (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.cfg        (cfg),
		.tdh        (tdh),
		.tdh_set    (tdh_set),
		.tdt        (tdt),
		.tdt_set    (tdt_set),
		.wb_done    (wb_done),
		.fetch_done (fetch_done),
		.fetch_num  (fetch_num),
		.tdh_fb     (tdh_fb),
		.host_fresh (host_fresh),
		.wb_addr    (wb_addr),
		.rd_addr    (rd_addr),
		.txqe       (txqe),
		.txd_low    (txd_low)
	);

	local_desc_queues i_local_desc_queues (
		.aclk            (aclk),
		.aresetn         (aresetn),
		.fetch_done      (fetch_done),
		.fetch_num       (fetch_num),
		.in_dequeue      (in_dequeue),
		.teng_done       (teng_done),
		.teng_rs         (teng_rs),
		.wb_done         (wb_done),
		.in_head         (in_head),
		.in_tail         (in_tail),
		.out_head        (out_head),
		.in_num          (in_num),
		.out_num         (out_num),
		.local_pending   (local_pending),
		.local_available (local_available),
		.rs_flag         (rs_flag)
	);

	// Response payload from the DMA engine carries nothing of interest
	idma_scheduler #(
		.max_burst (max_burst)
	) i_idma_scheduler (
		.aclk            (aclk),
		.aresetn         (aresetn),
		.cfg             (cfg),
		.host_fresh      (host_fresh),
		.wb_addr         (wb_addr),
		.rd_addr         (rd_addr),
		.out_num         (out_num),
		.local_pending   (local_pending),
		.local_available (local_available),
		.out_head        (out_head),
		.in_tail         (in_tail),
		.rs_flag         (rs_flag),
		.cmd             (idma_cmd),
		.cmd_valid       (idma_cmd_valid),
		.cmd_ready       (idma_cmd_ready),
		.rsp_valid       (idma_rsp_valid),
		.rsp_last        (idma_rsp.last),
		.rsp_ready       (idma_rsp_ready),
		.wb_done         (wb_done),
		.fetch_done      (fetch_done),
		.fetch_num       (fetch_num),
		.txdw            (txdw)
	);

	teng_dispatcher i_teng_dispatcher (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.en         (cfg.en),
		.in_num     (in_num),
		.in_head    (in_head),
		.cmd        (teng_cmd),
		.cmd_valid  (teng_cmd_valid),
		.cmd_ready  (teng_cmd_ready),
		.rsp        (teng_rsp),
		.rsp_valid  (teng_rsp_valid),
		.rsp_ready  (teng_rsp_ready),
		.in_dequeue (in_dequeue),
		.teng_done  (teng_done),
		.teng_rs    (teng_rs)
	);

endmodule

// File: hw/teng_dispatcher.sv
`timescale 1ns/1ps

module teng_dispatcher import tx_desc_pkg::*; (
	input  logic         aclk,
	input  logic         aresetn,
	input  logic         en,
	input  slot_cnt_t    in_num,
	input  slot_idx_t    in_head,
	output stream_beat_t cmd,
	output logic         cmd_valid,
	input  logic         cmd_ready,
	input  stream_beat_t rsp,
	input  logic         rsp_valid,
	output logic         rsp_ready,
	output logic         in_dequeue,
	output logic         teng_done,
	output logic         teng_rs
);

	disp_state_t state;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state      <= disp_idle;
			cmd        <= '0;
			cmd_valid  <= 1'b0;
			rsp_ready  <= 1'b0;
			in_dequeue <= 1'b0;
			teng_done  <= 1'b0;
			teng_rs    <= 1'b0;
		end else begin
			case (state)
				disp_idle: begin
					if (en) begin
						state <= disp_ready;
					end
				end
				disp_ready: begin
					if (!en) begin
						state <= disp_idle;
					end else if (in_num != '0) begin
						// Single beat carrying the slot's local address
						cmd.data  <= {16'h0000, 16'(in_head) * 16'(desc_bytes)};
						cmd.last  <= 1'b1;
						cmd_valid <= 1'b1;
						state     <= disp_cmd;
					end
				end
				disp_cmd: begin
					if (cmd_ready) begin
						cmd_valid  <= 1'b0;
						in_dequeue <= 1'b1;
						state      <= disp_dequeue;
					end
				end
				disp_dequeue: begin
					in_dequeue <= 1'b0;
					rsp_ready  <= 1'b1;
					state      <= disp_ack;
				end
				disp_ack: begin
					if (rsp_valid && rsp.last) begin
						rsp_ready <= 1'b0;
						teng_done <= 1'b1;
						// RS flag of the finished descriptor
						teng_rs   <= rsp.data[16];
						state     <= disp_enqueue;
					end
				end
				disp_enqueue: begin
					teng_done <= 1'b0;
					state     <= disp_ready;
				end
				default: begin
					state <= disp_idle;
				end
			endcase
		end
	end

endmodule

// File: hw/idma_scheduler.sv
`timescale 1ns/1ps

module idma_scheduler import tx_desc_pkg::*; #(
	parameter int unsigned max_burst = 64
) (
	input  logic         aclk,
	input  logic         aresetn,
	input  tx_cfg_t      cfg,
	input  desc_idx_t    host_fresh,
	input  host_addr_t   wb_addr,
	input  host_addr_t   rd_addr,
	input  slot_cnt_t    out_num,
	input  slot_cnt_t    local_pending,
	input  slot_cnt_t    local_available,
	input  slot_idx_t    out_head,
	input  slot_idx_t    in_tail,
	input  logic         rs_flag,
	output stream_beat_t cmd,
	output logic         cmd_valid,
	input  logic         cmd_ready,
	input  logic         rsp_valid,
	input  logic         rsp_last,
	output logic         rsp_ready,
	output logic         wb_done,
	output logic         fetch_done,
	output slot_cnt_t    fetch_num,
	output logic         txdw
);

	localparam int unsigned cnt_w = $clog2(settle_cycles + 1);

	sched_state_t     state;
	logic [cnt_w-1:0] settle_cnt;
	logic             fetch_go;
	slot_cnt_t        fetch_size;
	logic [15:0]      wb_local;
	logic [15:0]      rd_local;
	logic [11:0]      fetch_bytes;
	host_addr_t       wb_sta_addr;

	// Only the status byte goes back to the host
	assign wb_local    = 16'(out_head) * 16'(desc_bytes) + 16'(sta_offset);
	assign wb_sta_addr = wb_addr + host_addr_t'(sta_offset);
	assign rd_local    = 16'(in_tail) * 16'(desc_bytes);
	assign fetch_bytes = 12'(fetch_num * desc_bytes);

	// Prefetch rule
	assign fetch_go = (local_available != '0) &&
		((((cfg.pthresh == '0) || (local_pending < slot_cnt_t'(cfg.pthresh))) &&
		(host_fresh > desc_idx_t'(cfg.hthresh))) ||
		(cfg.dpp && (local_pending == '0) && (host_fresh != '0)));

	always_comb begin
		if (cfg.dpp) begin
			fetch_size = slot_cnt_t'(1);
		end else begin
			fetch_size = slot_cnt_t'(max_burst);
			if (local_available < fetch_size) begin
				fetch_size = local_available;
			end
			if (host_fresh < desc_idx_t'(fetch_size)) begin
				fetch_size = slot_cnt_t'(host_fresh);
			end
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state      <= sched_idle;
			settle_cnt <= '0;
			fetch_num  <= '0;
			cmd        <= '0;
			cmd_valid  <= 1'b0;
			rsp_ready  <= 1'b0;
			wb_done    <= 1'b0;
			fetch_done <= 1'b0;
			txdw       <= 1'b0;
		end else begin
			case (state)
				sched_idle: begin
					if (cfg.en) begin
						state <= sched_ready;
					end
				end
				sched_ready: begin
					if (!cfg.en) begin
						state <= sched_idle;
					end else if (out_num != '0) begin
						// Completed slots first
						if (rs_flag) begin
							cmd.data  <= {1'b1, 3'b000, 12'd1, wb_local};
							cmd.last  <= 1'b0;
							cmd_valid <= 1'b1;
							state     <= sched_wb0;
						end else begin
							wb_done <= 1'b1;
							state   <= sched_dequeue;
						end
					end else if (fetch_go) begin
						fetch_num <= fetch_size;
						state     <= sched_set_size;
					end
				end
				sched_wb0: begin
					if (cmd_ready) begin
						cmd.data <= wb_sta_addr[31:0];
						state    <= sched_wb1;
					end
				end
				sched_wb1: begin
					if (cmd_ready) begin
						cmd.data <= wb_sta_addr[63:32];
						cmd.last <= 1'b1;
						state    <= sched_wb2;
					end
				end
				sched_wb2: begin
					if (cmd_ready) begin
						cmd_valid <= 1'b0;
						rsp_ready <= 1'b1;
						state     <= sched_wb_ack;
					end
				end
				sched_wb_ack: begin
					if (rsp_valid && rsp_last) begin
						rsp_ready <= 1'b0;
						wb_done   <= 1'b1;
						txdw      <= 1'b1;
						state     <= sched_dequeue;
					end
				end
				sched_dequeue: begin
					wb_done    <= 1'b0;
					txdw       <= 1'b0;
					settle_cnt <= cnt_w'(settle_cycles - 1);
					state      <= sched_settle;
				end
				sched_set_size: begin
					cmd.data  <= {1'b0, 3'b000, fetch_bytes, rd_local};
					cmd.last  <= 1'b0;
					cmd_valid <= 1'b1;
					state     <= sched_fetch0;
				end
				sched_fetch0: begin
					if (cmd_ready) begin
						cmd.data <= rd_addr[31:0];
						state    <= sched_fetch1;
					end
				end
				sched_fetch1: begin
					if (cmd_ready) begin
						cmd.data <= rd_addr[63:32];
						cmd.last <= 1'b1;
						state    <= sched_fetch2;
					end
				end
				sched_fetch2: begin
					if (cmd_ready) begin
						cmd_valid <= 1'b0;
						rsp_ready <= 1'b1;
						state     <= sched_fetch_ack;
					end
				end
				sched_fetch_ack: begin
					if (rsp_valid && rsp_last) begin
						rsp_ready  <= 1'b0;
						fetch_done <= 1'b1;
						state      <= sched_enqueue;
					end
				end
				sched_enqueue: begin
					fetch_done <= 1'b0;
					settle_cnt <= cnt_w'(settle_cycles - 1);
					state      <= sched_settle;
				end
				sched_settle: begin
					// Let the host pointer pipeline catch up
					if (settle_cnt == '0) begin
						state <= sched_ready;
					end else begin
						settle_cnt <= settle_cnt - 1'b1;
					end
				end
				default: begin
					state <= sched_idle;
				end
			endcase
		end
	end

endmodule

// File: hw/local_desc_queues.sv
`timescale 1ns/1ps

module local_desc_queues import tx_desc_pkg::*; (
	input  logic      aclk,
	input  logic      aresetn,
	input  logic      fetch_done,
	input  slot_cnt_t fetch_num,
	input  logic      in_dequeue,
	input  logic      teng_done,
	input  logic      teng_rs,
	input  logic      wb_done,
	output slot_idx_t in_head,
	output slot_idx_t in_tail,
	output slot_idx_t out_head,
	output slot_cnt_t in_num,
	output slot_cnt_t out_num,
	output slot_cnt_t local_pending,
	output slot_cnt_t local_available,
	output logic      rs_flag
);

	slot_idx_t out_tail;
	slot_cnt_t fetch_add;
	logic      rs_mem [local_slots];

	assign fetch_add = fetch_done ? fetch_num : '0;

	// Input queue holds fetched slots not yet sent to the engine
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			in_head <= '0;
			in_tail <= '0;
			in_num  <= '0;
		end else begin
			in_tail <= in_tail + slot_idx_t'(fetch_add);
			in_head <= in_head + slot_idx_t'(in_dequeue);
			in_num  <= in_num + fetch_add - slot_cnt_t'(in_dequeue);
		end
	end

	// Output queue holds slots the engine has finished with
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			out_head <= '0;
			out_tail <= '0;
			out_num  <= '0;
		end else begin
			out_tail <= out_tail + slot_idx_t'(teng_done);
			out_head <= out_head + slot_idx_t'(wb_done);
			out_num  <= out_num + slot_cnt_t'(teng_done) - slot_cnt_t'(wb_done);
		end
	end

	// A slot stays pending from fetch until write-back
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			local_pending   <= '0;
			local_available <= slot_cnt_t'(local_slots);
		end else begin
			local_pending   <= local_pending + fetch_add - slot_cnt_t'(wb_done);
			local_available <= local_available - fetch_add + slot_cnt_t'(wb_done);
		end
	end

	always_ff @(posedge aclk) begin
		if (teng_done) begin
			rs_mem[out_tail] <= teng_rs;
		end
	end

	// Bypass when the slot at out_head is being written in this cycle
	always_ff @(posedge aclk) begin
		if (teng_done && (out_tail == out_head)) begin
			rs_flag <= teng_rs;
		end else begin
			rs_flag <= rs_mem[out_head];
		end
	end

endmodule

// File: hw/host_ring_tracker.sv
`timescale 1ns/1ps

module host_ring_tracker import tx_desc_pkg::*; (
	input  logic       aclk,
	input  logic       aresetn,
	input  tx_cfg_t    cfg,
	input  desc_idx_t  tdh,
	input  logic       tdh_set,
	input  desc_idx_t  tdt,
	input  logic       tdt_set,
	input  logic       wb_done,
	input  logic       fetch_done,
	input  slot_cnt_t  fetch_num,
	output desc_idx_t  tdh_fb,
	output desc_idx_t  host_fresh,
	output host_addr_t wb_addr,
	output host_addr_t rd_addr,
	output logic       txqe,
	output logic       txd_low
);

	desc_idx_t   ring_len;
	logic [4:0]  stage;
	logic        update;
	desc_idx_t   head;
	desc_idx_t   curr;
	desc_idx_t   tail;
	logic [16:0] head_n0;
	logic [16:0] curr_n0;
	desc_idx_t   head_n1;
	desc_idx_t   curr_n1;
	logic [16:0] pend_n0;
	logic [16:0] pend_n1;
	desc_idx_t   pend_n2;
	logic [16:0] fresh_n0;
	logic [16:0] fresh_n1;
	desc_idx_t   fresh_n2;

	// Fold a sum below twice the ring length back into the ring
	function automatic desc_idx_t wrap(input logic [16:0] v, input desc_idx_t len);
		if (v >= {1'b0, len}) begin
			return desc_idx_t'(v - {1'b0, len});
		end
		return desc_idx_t'(v);
	endfunction

	assign ring_len = {cfg.len, 3'b000};
	assign update   = tdh_set | tdt_set | wb_done | fetch_done;
	assign tdh_fb   = head;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			stage   <= '0;
			head_n0 <= '0;
			curr_n0 <= '0;
			head    <= '0;
			curr    <= '0;
			tail    <= '0;
		end else begin
			stage <= {stage[3:0], update};
			// Host write of TDH restarts both read pointers
			if (tdh_set) begin
				head_n0 <= {1'b0, tdh};
				curr_n0 <= {1'b0, tdh};
			end else begin
				if (wb_done) begin
					head_n0 <= {1'b0, head} + 17'd1;
				end
				if (fetch_done) begin
					curr_n0 <= {1'b0, curr} + 17'(fetch_num);
				end
			end
			if (tdt_set) begin
				tail <= tdt;
			end
			if (stage[1]) begin
				head <= head_n1;
				curr <= curr_n1;
			end
		end
	end

	// Staged pending and fresh arithmetic
	always_ff @(posedge aclk) begin
		if (stage[0]) begin
			head_n1 <= wrap(head_n0, ring_len);
			curr_n1 <= wrap(curr_n0, ring_len);
		end
		if (stage[1]) begin
			pend_n0  <= {1'b0, tail} + {1'b0, ring_len};
			fresh_n0 <= {1'b0, tail} + {1'b0, ring_len};
		end
		if (stage[2]) begin
			pend_n1  <= pend_n0 - {1'b0, head};
			fresh_n1 <= fresh_n0 - {1'b0, curr};
		end
		if (stage[3]) begin
			pend_n2  <= wrap(pend_n1, ring_len);
			fresh_n2 <= wrap(fresh_n1, ring_len);
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			host_fresh <= '0;
			txqe       <= 1'b0;
			txd_low    <= 1'b0;
		end else begin
			if (stage[4]) begin
				host_fresh <= fresh_n2;
			end
			txqe    <= stage[4] && (pend_n2 == '0);
			txd_low <= stage[4] && (pend_n2 < desc_idx_t'(cfg.lwthresh));
		end
	end

	always_ff @(posedge aclk) begin
		wb_addr <= cfg.base + (host_addr_t'(head) * desc_bytes);
		rd_addr <= cfg.base + (host_addr_t'(curr) * desc_bytes);
	end

endmodule

// File: hw/tx_desc_pkg.sv
package tx_desc_pkg;

	// Widths with a meaning of their own
	typedef logic [15:0] desc_idx_t;
	typedef logic [63:0] host_addr_t;
	typedef logic [7:0]  slot_idx_t;
	typedef logic [8:0]  slot_cnt_t;
	typedef logic [31:0] dma_word_t;
	typedef logic [5:0]  thresh_t;

	localparam int unsigned desc_bytes    = 16;
	localparam int unsigned local_slots   = 256;
	// Pointer pipeline depth plus one spare cycle
	localparam int unsigned settle_cycles = 6;
	// Status byte sits in the fourth dword of a descriptor
	localparam int unsigned sta_offset    = 12;

	// Ring setup from the register block
	typedef struct packed {
		logic        en;
		host_addr_t  base;
		logic [12:0] len;      // units of eight descriptors
		logic        dpp;
		thresh_t     pthresh;
		thresh_t     hthresh;
		thresh_t     lwthresh;
	} tx_cfg_t;

	typedef struct packed {
		dma_word_t data;
		logic      last;
	} stream_beat_t;

	typedef enum logic [3:0] {
		sched_idle, sched_ready,
		sched_wb0, sched_wb1, sched_wb2, sched_wb_ack,
		sched_dequeue, sched_set_size,
		sched_fetch0, sched_fetch1, sched_fetch2, sched_fetch_ack,
		sched_enqueue, sched_settle
	} sched_state_t;

	typedef enum logic [2:0] {
		disp_idle, disp_ready, disp_cmd, disp_dequeue, disp_ack, disp_enqueue
	} disp_state_t;

endpackage
